// ==== all.f ====
+incdir+test
rtl/tlb_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_match.sv
rtl/tlb_lookup_pipe.sv
rtl/dmw_map.sv
rtl/tlb_search.sv
rtl/tlb_top.sv
test/tb_clock.sv
test/tb_tlb.sv

// ==== rtl/dmw_map.sv ====
module dmw_map (
    input  logic             clk,
    input  logic             rstn,
    input  logic             flush,
    input  logic             s2_valid,
    input  tlb_pkg::vpn_t    s2_vpn,
    input  logic             s2_hit_any,
    input  logic             s2_v,
    input  logic             s2_mat0,
    input  tlb_pkg::ppn_t    s2_ppn,
    input  logic             pg,
    input  tlb_pkg::csr_t    crmd,
    input  tlb_pkg::csr_t    dmw0,
    input  tlb_pkg::csr_t    dmw1,
    output logic             pa_valid,
    output tlb_pkg::ppn_t    pa_ppn,
    output logic             pa_cached,
    output logic             tlb_refill,
    output logic             page_invalid
);

    logic            win0;
    logic            win1;
    logic            use_tlb;
    tlb_pkg::ppn_t   ppn_next;
    logic            cached_next;

    // VSEG covers address bits 31..29 which are the top three VPN bits
    assign win0 = dmw0[tlb_pkg::DMW_VSEG_HI:tlb_pkg::DMW_VSEG_LO] == s2_vpn[19:17];
    assign win1 = dmw1[tlb_pkg::DMW_VSEG_HI:tlb_pkg::DMW_VSEG_LO] == s2_vpn[19:17];
    assign use_tlb = pg && !win0 && !win1;

    always_comb begin
        if (!pg) begin
            ppn_next = s2_vpn;
            cached_next = crmd[tlb_pkg::CRMD_DATM];
        end else if (win0) begin
            ppn_next = {dmw0[tlb_pkg::DMW_PSEG_HI:tlb_pkg::DMW_PSEG_LO], s2_vpn[16:0]};
            cached_next = dmw0[tlb_pkg::DMW_CACHED];
        end else if (win1) begin
            ppn_next = {dmw1[tlb_pkg::DMW_PSEG_HI:tlb_pkg::DMW_PSEG_LO], s2_vpn[16:0]};
            cached_next = dmw1[tlb_pkg::DMW_CACHED];
        end else begin
            ppn_next = s2_ppn;
            cached_next = s2_mat0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pa_valid <= 1'b0;
            pa_ppn <= '0;
            pa_cached <= 1'b0;
            tlb_refill <= 1'b0;
            page_invalid <= 1'b0;
        end else if (flush) begin
            pa_valid <= 1'b0;
            pa_ppn <= '0;
            pa_cached <= 1'b0;
            tlb_refill <= 1'b0;
            page_invalid <= 1'b0;
        end else begin
            pa_valid <= s2_valid;
            pa_ppn <= ppn_next;
            pa_cached <= cached_next;
            tlb_refill <= s2_valid && use_tlb && !s2_hit_any;
            page_invalid <= s2_valid && use_tlb && s2_hit_any && !s2_v;
        end
    end

endmodule

// ==== rtl/tlb_entry_array.sv ====
module tlb_entry_array #(
    parameter int TLB_NUM = 32,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_en,
    input  logic [IDX_W-1:0]       wr_index,
    input  tlb_pkg::tlb_cmp_t      wr_cmp,
    input  tlb_pkg::tlb_trans_t    wr_trans0,
    input  tlb_pkg::tlb_trans_t    wr_trans1,
    input  logic                   inv_en,
    input  tlb_pkg::invtlb_op_t    inv_op,
    input  tlb_pkg::asid_t         inv_asid,
    input  tlb_pkg::vppn_t         inv_vppn,
    output tlb_pkg::tlb_cmp_t      entry_cmp [TLB_NUM],
    output tlb_pkg::tlb_trans_t    entry_trans0 [TLB_NUM],
    output tlb_pkg::tlb_trans_t    entry_trans1 [TLB_NUM]
);

    logic [TLB_NUM-1:0] kill;

    // Entries selected by the invalidate op
    always_comb begin
        logic g;
        logic asid_eq;
        logic vppn_eq;
        for (int i = 0; i < TLB_NUM; i++) begin
            g = entry_cmp[i][tlb_pkg::CMP_G];
            asid_eq = entry_cmp[i][tlb_pkg::CMP_ASID_HI:tlb_pkg::CMP_ASID_LO] == inv_asid;
            vppn_eq = entry_cmp[i][tlb_pkg::CMP_VPPN_HI:tlb_pkg::CMP_VPPN_LO] == inv_vppn;
            case (inv_op)
                tlb_pkg::INV_ALL,
                tlb_pkg::INV_ALL_ALT:  kill[i] = 1'b1;
                tlb_pkg::INV_GLOBAL:   kill[i] = g;
                tlb_pkg::INV_LOCAL:    kill[i] = !g;
                tlb_pkg::INV_ASID:     kill[i] = !g && asid_eq;
                tlb_pkg::INV_ASID_VA:  kill[i] = !g && asid_eq && vppn_eq;
                tlb_pkg::INV_GASID_VA: kill[i] = (g || asid_eq) && vppn_eq;
                default:               kill[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                entry_cmp[i] <= '0;
                entry_trans0[i] <= '0;
                entry_trans1[i] <= '0;
            end
        end else if (wr_en) begin
            // Write takes priority over a same-cycle invalidate
            entry_cmp[wr_index] <= wr_cmp;
            entry_trans0[wr_index] <= wr_trans0;
            entry_trans1[wr_index] <= wr_trans1;
        end else if (inv_en) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (kill[i]) begin
                    entry_cmp[i][tlb_pkg::CMP_E] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== rtl/tlb_lookup_pipe.sv ====
module tlb_lookup_pipe #(
    parameter int TLB_NUM = 32
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   req_valid,
    input  tlb_pkg::vpn_t          req_vpn,
    input  logic [TLB_NUM-1:0]     hit,
    input  tlb_pkg::tlb_cmp_t      entry_cmp [TLB_NUM],
    input  tlb_pkg::tlb_trans_t    entry_trans0 [TLB_NUM],
    input  tlb_pkg::tlb_trans_t    entry_trans1 [TLB_NUM],
    output logic                   s2_valid,
    output tlb_pkg::vpn_t          s2_vpn,
    output logic                   s2_hit_any,
    output logic                   s2_v,
    output logic                   s2_mat0,
    output tlb_pkg::ppn_t          s2_ppn
);

    logic                s1_valid;
    tlb_pkg::vpn_t       s1_vpn;
    logic [TLB_NUM-1:0]  s1_hit;
    logic [TLB_NUM-1:0]  s1_odd;
    logic [TLB_NUM-1:0]  s1_big;
    logic [TLB_NUM-1:0]  odd_in;
    logic [TLB_NUM-1:0]  big_in;
    logic                sel_v;
    logic                sel_mat0;
    tlb_pkg::ppn_t       sel_ppn;
    logic                big_hit;
    tlb_pkg::ppn_t       page_ppn;

    // Odd half is picked by bit 12 for 4 KB pages, bit 21 for 4 MB
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            big_in[i] = entry_cmp[i][tlb_pkg::CMP_PS_HI:tlb_pkg::CMP_PS_LO] != tlb_pkg::PS_4K;
            odd_in[i] = big_in[i] ? req_vpn[9] : req_vpn[0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s1_vpn <= '0;
            s1_hit <= '0;
            s1_odd <= '0;
            s1_big <= '0;
        end else if (flush) begin
            s1_valid <= 1'b0;
            s1_vpn <= '0;
            s1_hit <= '0;
            s1_odd <= '0;
            s1_big <= '0;
        end else if (!stall) begin
            s1_valid <= req_valid;
            s1_vpn <= req_vpn;
            s1_hit <= hit;
            s1_odd <= odd_in;
            s1_big <= big_in;
        end
    end

    // One-hot OR of the hitting entry's chosen half
    always_comb begin
        tlb_pkg::tlb_trans_t half;
        sel_v = 1'b0;
        sel_mat0 = 1'b0;
        sel_ppn = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            half = s1_odd[i] ? entry_trans1[i] : entry_trans0[i];
            if (s1_hit[i]) begin
                sel_v = sel_v | half[tlb_pkg::TR_V];
                sel_mat0 = sel_mat0 | half[tlb_pkg::TR_MAT_LO];
                sel_ppn = sel_ppn | half[tlb_pkg::TR_PPN_HI:tlb_pkg::TR_PPN_LO];
            end
        end
    end

    assign big_hit = |(s1_hit & s1_big);

    // Low 9 bits of a 4 MB page come from the address
    always_comb begin
        if (!sel_v) begin
            page_ppn = '0;
        end else if (big_hit) begin
            page_ppn = {sel_ppn[19:9], s1_vpn[8:0]};
        end else begin
            page_ppn = sel_ppn;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s2_valid <= 1'b0;
            s2_vpn <= '0;
            s2_hit_any <= 1'b0;
            s2_v <= 1'b0;
            s2_mat0 <= 1'b0;
            s2_ppn <= '0;
        end else if (flush) begin
            s2_valid <= 1'b0;
            s2_vpn <= '0;
            s2_hit_any <= 1'b0;
            s2_v <= 1'b0;
            s2_mat0 <= 1'b0;
            s2_ppn <= '0;
        end else if (!stall) begin
            s2_valid <= s1_valid;
            s2_vpn <= s1_vpn;
            s2_hit_any <= |s1_hit;
            s2_v <= sel_v;
            s2_mat0 <= sel_mat0;
            s2_ppn <= page_ppn;
        end
    end

endmodule

// ==== rtl/tlb_match.sv ====
module tlb_match #(
    parameter int TLB_NUM = 32
) (
    input  tlb_pkg::vpn_t        vpn,
    input  tlb_pkg::asid_t       asid,
    input  tlb_pkg::tlb_cmp_t    entry_cmp [TLB_NUM],
    output logic [TLB_NUM-1:0]   hit
);

    always_comb begin
        logic e;
        logic g;
        logic asid_eq;
        logic is_4k;
        logic vppn_eq;
        tlb_pkg::vppn_t vppn;
        for (int i = 0; i < TLB_NUM; i++) begin
            e = entry_cmp[i][tlb_pkg::CMP_E];
            g = entry_cmp[i][tlb_pkg::CMP_G];
            asid_eq = entry_cmp[i][tlb_pkg::CMP_ASID_HI:tlb_pkg::CMP_ASID_LO] == asid;
            is_4k = entry_cmp[i][tlb_pkg::CMP_PS_HI:tlb_pkg::CMP_PS_LO] == tlb_pkg::PS_4K;
            vppn = entry_cmp[i][tlb_pkg::CMP_VPPN_HI:tlb_pkg::CMP_VPPN_LO];
            // 4 MB pairs only compare address bits 31..23
            if (is_4k) begin
                vppn_eq = vppn == vpn[19:1];
            end else begin
                vppn_eq = vppn[18:10] == vpn[19:11];
            end
            hit[i] = e && (g || asid_eq) && vppn_eq;
        end
    end

endmodule

// ==== rtl/tlb_pkg.sv ====
package tlb_pkg;

    typedef logic [19:0] vpn_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [36:0] tlb_cmp_t;
    typedef logic [25:0] tlb_trans_t;
    typedef logic [31:0] csr_t;
    typedef logic [4:0]  invtlb_op_t;

    // Compare word layout
    localparam int CMP_VPPN_LO = 0;
    localparam int CMP_VPPN_HI = 18;
    localparam int CMP_PS_LO   = 19;
    localparam int CMP_PS_HI   = 24;
    localparam int CMP_G       = 25;
    localparam int CMP_ASID_LO = 26;
    localparam int CMP_ASID_HI = 35;
    localparam int CMP_E       = 36;

    // Translate word layout
    localparam int TR_PPN_LO = 0;
    localparam int TR_PPN_HI = 19;
    localparam int TR_PLV_LO = 20;
    localparam int TR_PLV_HI = 21;
    localparam int TR_MAT_LO = 22;
    localparam int TR_MAT_HI = 23;
    localparam int TR_D      = 24;
    localparam int TR_V      = 25;

    // Anything else is a 4 MB page
    localparam logic [5:0] PS_4K = 6'd12;

    localparam int DMW_VSEG_LO = 29;
    localparam int DMW_VSEG_HI = 31;
    localparam int DMW_PSEG_LO = 25;
    localparam int DMW_PSEG_HI = 27;
    localparam int DMW_CACHED  = 4;
    localparam int CRMD_DATM   = 7;

    localparam invtlb_op_t INV_ALL      = 5'd0;
    localparam invtlb_op_t INV_ALL_ALT  = 5'd1;
    localparam invtlb_op_t INV_GLOBAL   = 5'd2;
    localparam invtlb_op_t INV_LOCAL    = 5'd3;
    localparam invtlb_op_t INV_ASID     = 5'd4;
    localparam invtlb_op_t INV_ASID_VA  = 5'd5;
    localparam invtlb_op_t INV_GASID_VA = 5'd6;

endpackage

// ==== rtl/tlb_search.sv ====
module tlb_search #(
    parameter int TLB_NUM = 32,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 search_req,
    input  logic [TLB_NUM-1:0]   hit,
    output logic                 search_done,
    output logic                 search_hit,
    output logic [IDX_W-1:0]     search_index
);

    logic                req_q;
    logic [TLB_NUM-1:0]  hit_q;
    logic [IDX_W-1:0]    low_idx;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_q <= 1'b0;
        end else begin
            req_q <= search_req;
        end
    end

    always_ff @(posedge clk) begin
        hit_q <= hit;
    end

    // Lowest set index wins
    always_comb begin
        low_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (hit_q[i]) begin
                low_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            search_done <= 1'b0;
            search_hit <= 1'b0;
            search_index <= '0;
        end else begin
            search_done <= req_q;
            if (req_q) begin
                search_hit <= |hit_q;
                search_index <= low_idx;
            end
        end
    end

endmodule

// ==== rtl/tlb_top.sv ====
module tlb_top #(
    parameter int TLB_NUM = 32,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   req_valid,
    input  tlb_pkg::vpn_t          req_vpn,
    input  tlb_pkg::asid_t         asid,
    input  logic                   pg,
    input  tlb_pkg::csr_t          crmd,
    input  tlb_pkg::csr_t          dmw0,
    input  tlb_pkg::csr_t          dmw1,
    input  logic                   wr_en,
    input  logic [IDX_W-1:0]       wr_index,
    input  tlb_pkg::tlb_cmp_t      wr_cmp,
    input  tlb_pkg::tlb_trans_t    wr_trans0,
    input  tlb_pkg::tlb_trans_t    wr_trans1,
    input  logic                   inv_en,
    input  tlb_pkg::invtlb_op_t    inv_op,
    input  tlb_pkg::asid_t         inv_asid,
    input  tlb_pkg::vppn_t         inv_vppn,
    input  logic                   search_req,
    input  tlb_pkg::vppn_t         search_vppn,
    output logic                   pa_valid,
    output tlb_pkg::ppn_t          pa_ppn,
    output logic                   pa_cached,
    output logic                   tlb_refill,
    output logic                   page_invalid,
    output logic                   search_done,
    output logic                   search_hit,
    output logic [IDX_W-1:0]       search_index
);

    tlb_pkg::tlb_cmp_t    entry_cmp [TLB_NUM];
    tlb_pkg::tlb_trans_t  entry_trans0 [TLB_NUM];
    tlb_pkg::tlb_trans_t  entry_trans1 [TLB_NUM];
    logic [TLB_NUM-1:0]   lookup_hit;
    logic [TLB_NUM-1:0]   search_hit_vec;
    logic                 s2_valid;
    tlb_pkg::vpn_t        s2_vpn;
    logic                 s2_hit_any;
    logic                 s2_v;
    logic                 s2_mat0;
    tlb_pkg::ppn_t        s2_ppn;

    tlb_entry_array #(.TLB_NUM(TLB_NUM)) u_array (
        .clk          (clk),
        .rstn         (rstn),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_cmp       (wr_cmp),
        .wr_trans0    (wr_trans0),
        .wr_trans1    (wr_trans1),
        .inv_en       (inv_en),
        .inv_op       (inv_op),
        .inv_asid     (inv_asid),
        .inv_vppn     (inv_vppn),
        .entry_cmp    (entry_cmp),
        .entry_trans0 (entry_trans0),
        .entry_trans1 (entry_trans1)
    );

    tlb_match #(.TLB_NUM(TLB_NUM)) u_lookup_match (
        .vpn       (req_vpn),
        .asid      (asid),
        .entry_cmp (entry_cmp),
        .hit       (lookup_hit)
    );

    // Search compares a page pair, so the even-page bit is zero
    tlb_match #(.TLB_NUM(TLB_NUM)) u_search_match (
        .vpn       ({search_vppn, 1'b0}),
        .asid      (asid),
        .entry_cmp (entry_cmp),
        .hit       (search_hit_vec)
    );

    tlb_lookup_pipe #(.TLB_NUM(TLB_NUM)) u_lookup_pipe (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .stall        (stall),
        .req_valid    (req_valid),
        .req_vpn      (req_vpn),
        .hit          (lookup_hit),
        .entry_cmp    (entry_cmp),
        .entry_trans0 (entry_trans0),
        .entry_trans1 (entry_trans1),
        .s2_valid     (s2_valid),
        .s2_vpn       (s2_vpn),
        .s2_hit_any   (s2_hit_any),
        .s2_v         (s2_v),
        .s2_mat0      (s2_mat0),
        .s2_ppn       (s2_ppn)
    );

    dmw_map u_dmw_map (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .s2_valid     (s2_valid),
        .s2_vpn       (s2_vpn),
        .s2_hit_any   (s2_hit_any),
        .s2_v         (s2_v),
        .s2_mat0      (s2_mat0),
        .s2_ppn       (s2_ppn),
        .pg           (pg),
        .crmd         (crmd),
        .dmw0         (dmw0),
        .dmw1         (dmw1),
        .pa_valid     (pa_valid),
        .pa_ppn       (pa_ppn),
        .pa_cached    (pa_cached),
        .tlb_refill   (tlb_refill),
        .page_invalid (page_invalid)
    );

    tlb_search #(.TLB_NUM(TLB_NUM)) u_search (
        .clk          (clk),
        .rstn         (rstn),
        .search_req   (search_req),
        .hit          (search_hit_vec),
        .search_done  (search_done),
        .search_hit   (search_hit),
        .search_index (search_index)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the TLB testbench with Verilator
cd "$(dirname "$0")" &&
    verilator --binary --timing --top-module tb_tlb -f all.f &&
    ./obj_dir/Vtb_tlb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release away from the clock edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 10);
        rstn = 1'b1;
    end

endmodule

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run(string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
endtask

task automatic check_ppn(string name, tlb_pkg::ppn_t exp, tlb_pkg::ppn_t act);
    if (act !== exp) begin
        abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
        abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    end
endtask

task automatic check_index(string name, logic [IDX_W-1:0] exp, logic [IDX_W-1:0] act);
    if (act !== exp) begin
        abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    end
endtask

`endif

// ==== test/tb_tlb.sv ====
module tb_tlb;

    localparam int TLB_NUM = 32;
    localparam int IDX_W = $clog2(TLB_NUM);
    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic                   clk;
    logic                   rstn;
    logic                   flush;
    logic                   stall;
    logic                   req_valid;
    tlb_pkg::vpn_t          req_vpn;
    tlb_pkg::asid_t         asid;
    logic                   pg;
    tlb_pkg::csr_t          crmd;
    tlb_pkg::csr_t          dmw0;
    tlb_pkg::csr_t          dmw1;
    logic                   wr_en;
    logic [IDX_W-1:0]       wr_index;
    tlb_pkg::tlb_cmp_t      wr_cmp;
    tlb_pkg::tlb_trans_t    wr_trans0;
    tlb_pkg::tlb_trans_t    wr_trans1;
    logic                   inv_en;
    tlb_pkg::invtlb_op_t    inv_op;
    tlb_pkg::asid_t         inv_asid;
    tlb_pkg::vppn_t         inv_vppn;
    logic                   search_req;
    tlb_pkg::vppn_t         search_vppn;
    logic                   pa_valid;
    tlb_pkg::ppn_t          pa_ppn;
    logic                   pa_cached;
    logic                   tlb_refill;
    logic                   page_invalid;
    logic                   search_done;
    logic                   search_hit;
    logic [IDX_W-1:0]       search_index;
    logic [15:0]            lfsr = 16'd21;

    `include "tb_checks.svh"

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    tlb_top #(.TLB_NUM(TLB_NUM)) u_tlb_top (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .stall        (stall),
        .req_valid    (req_valid),
        .req_vpn      (req_vpn),
        .asid         (asid),
        .pg           (pg),
        .crmd         (crmd),
        .dmw0         (dmw0),
        .dmw1         (dmw1),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_cmp       (wr_cmp),
        .wr_trans0    (wr_trans0),
        .wr_trans1    (wr_trans1),
        .inv_en       (inv_en),
        .inv_op       (inv_op),
        .inv_asid     (inv_asid),
        .inv_vppn     (inv_vppn),
        .search_req   (search_req),
        .search_vppn  (search_vppn),
        .pa_valid     (pa_valid),
        .pa_ppn       (pa_ppn),
        .pa_cached    (pa_cached),
        .tlb_refill   (tlb_refill),
        .page_invalid (page_invalid),
        .search_done  (search_done),
        .search_hit   (search_hit),
        .search_index (search_index)
    );

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic tlb_pkg::vpn_t rand_vpn();
        tlb_pkg::vpn_t v;
        logic fb;
        v = '0;
        for (int i = 0; i < 20; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[18:0], fb};
        end
        return v;
    endfunction

    function automatic tlb_pkg::tlb_cmp_t cmp_word(logic g, tlb_pkg::asid_t a, logic [5:0] ps,
                                                   tlb_pkg::vppn_t vppn);
        tlb_pkg::tlb_cmp_t c;
        c = '0;
        c[tlb_pkg::CMP_E] = 1'b1;
        c[tlb_pkg::CMP_G] = g;
        c[tlb_pkg::CMP_ASID_HI:tlb_pkg::CMP_ASID_LO] = a;
        c[tlb_pkg::CMP_PS_HI:tlb_pkg::CMP_PS_LO] = ps;
        c[tlb_pkg::CMP_VPPN_HI:tlb_pkg::CMP_VPPN_LO] = vppn;
        return c;
    endfunction

    function automatic tlb_pkg::tlb_trans_t trans_word(logic v, logic mat0, tlb_pkg::ppn_t ppn);
        tlb_pkg::tlb_trans_t t;
        t = '0;
        t[tlb_pkg::TR_V] = v;
        t[tlb_pkg::TR_MAT_LO] = mat0;
        t[tlb_pkg::TR_PPN_HI:tlb_pkg::TR_PPN_LO] = ppn;
        return t;
    endfunction

    function automatic tlb_pkg::csr_t dmw_word(logic [2:0] vseg, logic [2:0] pseg, logic cached);
        tlb_pkg::csr_t w;
        w = '0;
        w[tlb_pkg::DMW_VSEG_HI:tlb_pkg::DMW_VSEG_LO] = vseg;
        w[tlb_pkg::DMW_PSEG_HI:tlb_pkg::DMW_PSEG_LO] = pseg;
        w[tlb_pkg::DMW_CACHED] = cached;
        return w;
    endfunction

    // Inputs change and outputs are sampled 10 units after the rising edge
    task automatic cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic write_entry(int idx, tlb_pkg::tlb_cmp_t c, tlb_pkg::tlb_trans_t t0,
                               tlb_pkg::tlb_trans_t t1);
        wr_en = 1'b1;
        wr_index = IDX_W'(idx);
        wr_cmp = c;
        wr_trans0 = t0;
        wr_trans1 = t1;
        cycle();
        wr_en = 1'b0;
    endtask

    task automatic expect_pa(tlb_pkg::ppn_t ppn, logic cached);
        check_bit("pa_valid", 1'b1, pa_valid);
        check_ppn("pa_ppn", ppn, pa_ppn);
        check_bit("pa_cached", cached, pa_cached);
    endtask

    // One request into an idle pipe with its result 3 cycles later
    task automatic translate(tlb_pkg::vpn_t vpn, tlb_pkg::ppn_t ppn, logic cached,
                             logic refill, logic invalid);
        req_valid = 1'b1;
        req_vpn = vpn;
        cycle();
        req_valid = 1'b0;
        cycle();
        check_bit("pa_valid", 1'b0, pa_valid);
        cycle();
        expect_pa(ppn, cached);
        check_bit("tlb_refill", refill, tlb_refill);
        check_bit("page_invalid", invalid, page_invalid);
    endtask

    task automatic search_entry(tlb_pkg::vppn_t vppn, logic hit, int idx);
        search_req = 1'b1;
        search_vppn = vppn;
        cycle();
        search_req = 1'b0;
        check_bit("search_done", 1'b0, search_done);
        cycle();
        check_bit("search_done", 1'b1, search_done);
        check_bit("search_hit", hit, search_hit);
        if (hit) begin
            check_index("search_index", IDX_W'(idx), search_index);
        end
        cycle();
        check_bit("search_done", 1'b0, search_done);
    endtask

    task automatic direct_mode();
        tlb_pkg::vpn_t vpns[8];
        tlb_pkg::csr_t modes[2] = '{32'h0000_0080, 32'hFFFF_FF7F};
        logic mode_cached[2] = '{1'b1, 1'b0};
        pg = 1'b0;
        // Bit 7 alone set, then every bit but bit 7
        for (int m = 0; m < 2; m++) begin
            crmd = modes[m];
            for (int k = 0; k < 11; k++) begin
                if (k >= 3) begin
                    expect_pa(vpns[k-3], mode_cached[m]);
                end else begin
                    check_bit("pa_valid", 1'b0, pa_valid);
                end
                if (k < 8) begin
                    vpns[k] = rand_vpn();
                    req_valid = 1'b1;
                    req_vpn = vpns[k];
                end else begin
                    req_valid = 1'b0;
                end
                cycle();
            end
            check_bit("pa_valid", 1'b0, pa_valid);
        end
    endtask

    task automatic window_mapping();
        pg = 1'b1;
        dmw0 = dmw_word(3'b100, 3'b001, 1'b1);
        dmw1 = dmw_word(3'b101, 3'b010, 1'b0);
        translate({3'b100, 17'h0ABCD}, {3'b001, 17'h0ABCD}, 1'b1, 1'b0, 1'b0);
        translate({3'b101, 17'h12345}, {3'b010, 17'h12345}, 1'b0, 1'b0, 1'b0);
        // Overlapping windows
        dmw1 = dmw_word(3'b100, 3'b010, 1'b0);
        translate({3'b100, 17'h00F0F}, {3'b001, 17'h00F0F}, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic page_translation();
        pg = 1'b1;
        dmw0 = dmw_word(3'b111, 3'b000, 1'b0);
        dmw1 = dmw_word(3'b110, 3'b000, 1'b0);
        asid = 10'h005;
        write_entry(0, cmp_word(1'b0, 10'h005, tlb_pkg::PS_4K, 19'h00012),
                    trans_word(1'b1, 1'b1, 20'h11111), trans_word(1'b1, 1'b0, 20'h22222));
        // Global 4 MB pair covering VPN bits 19..11 equal to 3
        write_entry(1, cmp_word(1'b1, 10'h3FF, 6'd21, 19'h00C00),
                    trans_word(1'b1, 1'b1, 20'h40155), trans_word(1'b1, 1'b1, 20'h60000));
        write_entry(2, cmp_word(1'b0, 10'h005, tlb_pkg::PS_4K, 19'h00030),
                    trans_word(1'b0, 1'b1, 20'h33333), trans_word(1'b1, 1'b0, 20'h44444));
        translate(20'h00024, 20'h11111, 1'b1, 1'b0, 1'b0);
        translate(20'h00025, 20'h22222, 1'b0, 1'b0, 1'b0);
        translate(20'h018A5, 20'h400A5, 1'b1, 1'b0, 1'b0);
        translate(20'h01A13, 20'h60013, 1'b1, 1'b0, 1'b0);
        translate(20'h00060, 20'h00000, 1'b1, 1'b0, 1'b1);
        translate(20'h00061, 20'h44444, 1'b0, 1'b0, 1'b0);
        asid = 10'h123;
        translate(20'h018A5, 20'h400A5, 1'b1, 1'b0, 1'b0);
        translate(20'h00024, 20'h00000, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic invalidate_ops();
        tlb_pkg::vpn_t ent_vpn[4] = '{20'h00100, 20'h00200, 20'h00300, 20'h00200};
        tlb_pkg::ppn_t ent_ppn[4] = '{20'h0A000, 20'h0A001, 20'h0A002, 20'h0A003};
        tlb_pkg::asid_t ent_asid[4] = '{10'h005, 10'h005, 10'h007, 10'h009};
        tlb_pkg::asid_t look_asid[4] = '{10'h005, 10'h005, 10'h005, 10'h009};
        logic ent_g[4] = '{1'b0, 1'b0, 1'b1, 1'b0};
        tlb_pkg::invtlb_op_t ops[9] = '{tlb_pkg::INV_ALL, tlb_pkg::INV_ALL_ALT,
            tlb_pkg::INV_GLOBAL, tlb_pkg::INV_LOCAL, tlb_pkg::INV_ASID, tlb_pkg::INV_ASID_VA,
            tlb_pkg::INV_GASID_VA, tlb_pkg::INV_GASID_VA, 5'd7};
        tlb_pkg::vppn_t op_vppn[9] = '{19'h100, 19'h100, 19'h100, 19'h100, 19'h100,
            19'h100, 19'h180, 19'h100, 19'h100};
        // Bit i set when entry i survives
        logic [3:0] alive[9] = '{4'b0000, 4'b0000, 4'b1011, 4'b0100, 4'b1100,
            4'b1101, 4'b1011, 4'b1101, 4'b1111};
        for (int k = 0; k < 9; k++) begin
            for (int i = 0; i < 4; i++) begin
                write_entry(i, cmp_word(ent_g[i], ent_asid[i], tlb_pkg::PS_4K, ent_vpn[i][19:1]),
                            trans_word(1'b1, i[0], ent_ppn[i]), '0);
            end
            inv_en = 1'b1;
            inv_op = ops[k];
            inv_asid = 10'h005;
            inv_vppn = op_vppn[k];
            cycle();
            inv_en = 1'b0;
            for (int i = 0; i < 4; i++) begin
                asid = look_asid[i];
                if (alive[k][i]) begin
                    translate(ent_vpn[i], ent_ppn[i], i[0], 1'b0, 1'b0);
                end else begin
                    translate(ent_vpn[i], '0, 1'b0, 1'b1, 1'b0);
                end
            end
        end
    endtask

    task automatic index_search();
        inv_en = 1'b1;
        inv_op = tlb_pkg::INV_ALL;
        cycle();
        inv_en = 1'b0;
        write_entry(5, cmp_word(1'b0, 10'h005, tlb_pkg::PS_4K, 19'h00280), '0, '0);
        write_entry(9, cmp_word(1'b1, 10'h3FF, tlb_pkg::PS_4K, 19'h00280), '0, '0);
        write_entry(12, cmp_word(1'b1, 10'h000, 6'd21, 19'h04000), '0, '0);
        asid = 10'h005;
        search_entry(19'h00280, 1'b1, 5);
        asid = 10'h006;
        search_entry(19'h00280, 1'b1, 9);
        search_entry(19'h04355, 1'b1, 12);
        search_entry(19'h7FFFF, 1'b0, 0);
    endtask

    task automatic stall_and_flush();
        tlb_pkg::vpn_t vpns[3] = '{20'h11111, 20'h22222, 20'h33333};
        pg = 1'b0;
        crmd = 32'h0000_0080;
        for (int i = 0; i < 3; i++) begin
            req_valid = 1'b1;
            req_vpn = vpns[i];
            cycle();
        end
        req_valid = 1'b0;
        expect_pa(vpns[0], 1'b1);
        stall = 1'b1;
        cycle();
        // Stage 3 keeps reloading the held stage 2
        for (int i = 0; i < 3; i++) begin
            expect_pa(vpns[1], 1'b1);
            if (i == 2) begin
                stall = 1'b0;
            end
            cycle();
        end
        expect_pa(vpns[1], 1'b1);
        cycle();
        expect_pa(vpns[2], 1'b1);
        cycle();
        check_bit("pa_valid", 1'b0, pa_valid);
        for (int i = 0; i < 3; i++) begin
            req_valid = 1'b1;
            req_vpn = vpns[i];
            flush = (i == 2);
            cycle();
        end
        flush = 1'b0;
        req_valid = 1'b0;
        for (int i = 0; i < 3; i++) begin
            check_bit("pa_valid", 1'b0, pa_valid);
            cycle();
        end
        translate(20'h0BEEF, 20'h0BEEF, 1'b1, 1'b0, 1'b0);
    endtask

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        abort_run("Timeout: the tests did not finish in time");
    end

    initial begin
        flush = 1'b0;
        stall = 1'b0;
        req_valid = 1'b0;
        req_vpn = '0;
        asid = '0;
        pg = 1'b0;
        crmd = '0;
        dmw0 = '0;
        dmw1 = '0;
        wr_en = 1'b0;
        wr_index = '0;
        wr_cmp = '0;
        wr_trans0 = '0;
        wr_trans1 = '0;
        inv_en = 1'b0;
        inv_op = '0;
        inv_asid = '0;
        inv_vppn = '0;
        search_req = 1'b0;
        search_vppn = '0;
        @(posedge rstn);
        cycle();
        direct_mode();
        window_mapping();
        page_translation();
        invalidate_ops();
        index_search();
        stall_and_flush();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
